/* common/isaPkg.sv */
`default_nettype none

package isaPkg;

  localparam int dataWidth = 32;
  localparam int regAddrWidth = 5;

  typedef logic [dataWidth-1:0] word_t;
  typedef logic [regAddrWidth-1:0] regAddr_t;

  typedef enum logic [5:0] {
    RTYPE = 6'b000000,
    J     = 6'b000010,
    BEQ   = 6'b000100,
    BNE   = 6'b000101,
    ADDI  = 6'b001000,
    LUI   = 6'b001111,
    LW    = 6'b100011,
    SW    = 6'b101011
  } opcode_t;

  typedef enum logic [5:0] {
    ADD = 6'b100000,
    SUB = 6'b100010,
    AND = 6'b100100,
    OR  = 6'b100101,
    NOR = 6'b100111,
    SLT = 6'b101010
  } funct_t;

  typedef struct packed {
    opcode_t opcode;
    regAddr_t rs;
    regAddr_t rt;
    regAddr_t rd;
    logic [4:0] shamt;
    funct_t funct;
  } rType_t;

  typedef struct packed {
    opcode_t opcode;
    regAddr_t rs;
    regAddr_t rt;
    logic [15:0] imm;
  } iType_t;

  typedef struct packed {
    opcode_t opcode;
    logic [25:0] target;
  } jType_t;

  // Same fetched word seen in each format
  typedef union packed {
    rType_t r;
    iType_t i;
    jType_t j;
  } instr_t;

  typedef struct packed {
    word_t addr;
    word_t wdata;
    logic read;
    logic write;
  } memReq_t;

endpackage

`default_nettype wire

/* common/ctrlPkg.sv */
`default_nettype none

package ctrlPkg;

  typedef enum logic [4:0] {
    fetch      = 5'd0,
    decode     = 5'd1,
    exR        = 5'd2,
    exMem      = 5'd3,
    exI        = 5'd4,
    luiWb      = 5'd5,
    exBeq      = 5'd6,
    exBne      = 5'd7,
    exJ        = 5'd10,
    memRd      = 5'd11,
    memWr      = 5'd12,
    wbR        = 5'd13,
    wbI        = 5'd14,
    wbLw       = 5'd15,
    errorState = 5'd31
  } cpuState_t;

  typedef enum logic [2:0] {
    aluAnd = 3'b000,
    aluOr  = 3'b001,
    aluAdd = 3'b010,
    aluNor = 3'b100,
    aluSub = 3'b110,
    aluSlt = 3'b111
  } aluOp_t;

  localparam logic srcAPc = 1'b0;
  localparam logic srcARs = 1'b1;
  localparam logic [1:0] srcBReg = 2'd0;
  localparam logic [1:0] srcBFour = 2'd1;
  localparam logic [1:0] srcBImm = 2'd2;
  localparam logic [1:0] srcBOffset = 2'd3;
  localparam logic dstRt = 1'b0;
  localparam logic dstRd = 1'b1;
  localparam logic [1:0] wbAlu = 2'd0;
  localparam logic [1:0] wbMem = 2'd1;
  localparam logic [1:0] wbUpper = 2'd2;
  localparam logic [1:0] pcFromAlu = 2'd0;
  localparam logic [1:0] pcFromAluOut = 2'd1;
  localparam logic [1:0] pcFromJump = 2'd2;

  typedef struct packed {
    logic pcWrite;
    logic pcWriteCond;
    logic branchOnEqual;
    logic iOrD; // 0 PC, 1 ALU-output register
    logic memRead;
    logic memWrite;
    logic irWrite;
    logic regWrite;
    logic regDst;
    logic [1:0] memToReg;
    logic [1:0] pcSource;
    logic aluSrcA;
    logic [1:0] aluSrcB;
    aluOp_t aluOp;
  } ctrlWord_t;

  // Read instruction at PC and compute PC + 4
  localparam ctrlWord_t fetchCtrl = '{
    pcWrite: 1'b1,
    memRead: 1'b1,
    irWrite: 1'b1,
    pcSource: pcFromAlu,
    aluSrcA: srcAPc,
    aluSrcB: srcBFour,
    aluOp: aluAdd,
    default: '0
  };

endpackage

`default_nettype wire

/* datapath/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu
  import isaPkg::*, ctrlPkg::*;
(
  input  word_t  a,
  input  word_t  b,
  input  aluOp_t op,
  output word_t  result,
  output logic   zero
);

  always_comb begin
    case (op)
      aluAnd: result = a & b;
      aluOr:  result = a | b;
      aluAdd: result = a + b;
      aluSub: result = a - b;
      aluNor: result = ~(a | b);
      aluSlt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0; // Signed compare
      default: result = '0;
    endcase
  end

  assign zero = (result == '0);

endmodule

`default_nettype wire

/* datapath/regFile.sv */
`timescale 1ns/10ps
`default_nettype none

module regFile
  import isaPkg::*;
(
  input  wire logic clk,
  input  wire logic reset,
  input  regAddr_t  addrA,
  input  regAddr_t  addrB,
  input  regAddr_t  writeAddr,
  input  word_t     writeData,
  input  wire logic writeEn,
  output word_t     dataA,
  output word_t     dataB
);

  word_t regs [32];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && writeAddr != '0) begin
      regs[writeAddr] <= writeData; // $zero never written
    end
  end

  assign dataA = (addrA == '0) ? '0 : regs[addrA];
  assign dataB = (addrB == '0) ? '0 : regs[addrB];

endmodule

`default_nettype wire

/* datapath/dataPath.sv */
`timescale 1ns/10ps
`default_nettype none

module dataPath
  import isaPkg::*, ctrlPkg::*;
(
  input  wire logic clk,
  input  wire logic reset,
  input  ctrlWord_t ctrl,
  input  word_t     memData,
  input  wire logic memReady,
  output memReq_t   memReq,
  output instr_t    instr,
  output word_t     pc
);

  word_t mdr;
  word_t aluOut;
  word_t rsData;
  word_t rtData;
  word_t aluA;
  word_t aluB;
  word_t aluResult;
  word_t writeData;
  word_t nextPc;
  logic zero;
  logic pcLoad;
  logic [15:0] imm;
  regAddr_t writeAddr;

  assign imm = instr.i.imm;
  assign writeAddr = (ctrl.regDst == dstRd) ? instr.r.rd : instr.r.rt;

  regFile u_regFile (
    .clk(clk),
    .reset(reset),
    .addrA(instr.r.rs),
    .addrB(instr.r.rt),
    .writeAddr(writeAddr),
    .writeData(writeData),
    .writeEn(ctrl.regWrite),
    .dataA(rsData),
    .dataB(rtData)
  );

  assign aluA = (ctrl.aluSrcA == srcARs) ? rsData : pc;

  always_comb begin
    case (ctrl.aluSrcB)
      srcBReg:    aluB = rtData;
      srcBFour:   aluB = 32'd4;
      srcBImm:    aluB = {{16{imm[15]}}, imm};
      srcBOffset: aluB = {{14{imm[15]}}, imm, 2'b00};
      default:    aluB = rtData;
    endcase
  end

  alu u_alu (
    .a(aluA),
    .b(aluB),
    .op(ctrl.aluOp),
    .result(aluResult),
    .zero(zero)
  );

  always_comb begin
    case (ctrl.memToReg)
      wbMem:   writeData = mdr;
      wbUpper: writeData = {imm, 16'h0000};
      default: writeData = aluOut; // wbAlu
    endcase
  end

  always_comb begin
    case (ctrl.pcSource)
      pcFromAluOut: nextPc = aluOut;
      pcFromJump:   nextPc = {pc[31:28], instr.j.target, 2'b00};
      default:      nextPc = aluResult; // pcFromAlu
    endcase
  end

  // Fetch increments only once the instruction word arrives
  assign pcLoad = (ctrl.pcWrite && (memReady || !ctrl.irWrite)) ||
                  (ctrl.pcWriteCond && (zero == ctrl.branchOnEqual));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= '0;
      instr <= '0;
    end else begin
      if (pcLoad) pc <= nextPc;
      if (ctrl.irWrite && memReady) instr <= memData;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.memRead && memReady) mdr <= memData;
    aluOut <= aluResult;
  end

  assign memReq.addr = ctrl.iOrD ? aluOut : pc;
  assign memReq.wdata = rtData;
  assign memReq.read = ctrl.memRead;
  assign memReq.write = ctrl.memWrite && !ctrl.memRead;

endmodule

`default_nettype wire

/* control/ctrlFsm.sv */
`timescale 1ns/10ps
`default_nettype none

module ctrlFsm
  import isaPkg::*, ctrlPkg::*;
(
  input  wire logic clk,
  input  wire logic reset,
  input  instr_t    instr,
  input  wire logic memReady,
  output ctrlWord_t ctrl,
  output cpuState_t state
);

  cpuState_t nextState;
  ctrlWord_t nextCtrl;

  function automatic ctrlWord_t aluWord(input logic srcA, input logic [1:0] srcB,
                                        input aluOp_t op);
    ctrlWord_t w;
    w = '0;
    w.aluSrcA = srcA;
    w.aluSrcB = srcB;
    w.aluOp = op;
    return w;
  endfunction

  always_comb begin
    nextState = state; // Hold by default, covers memory waits
    nextCtrl = ctrl;
    case (state)
      fetch: begin
        if (memReady) begin
          nextState = decode;
          nextCtrl = aluWord(srcAPc, srcBOffset, aluAdd); // Branch target ahead of time
        end
      end
      decode: begin
        nextCtrl = aluWord(srcARs, srcBImm, aluAdd);
        case (instr.r.opcode)
          RTYPE: begin
            nextState = exR;
            nextCtrl.aluSrcB = srcBReg;
            case (instr.r.funct)
              ADD: nextCtrl.aluOp = aluAdd;
              SUB: nextCtrl.aluOp = aluSub;
              AND: nextCtrl.aluOp = aluAnd;
              OR:  nextCtrl.aluOp = aluOr;
              NOR: nextCtrl.aluOp = aluNor;
              SLT: nextCtrl.aluOp = aluSlt;
              default: begin
                nextState = errorState; // Unknown funct
                nextCtrl = '0;
              end
            endcase
          end
          LW, SW: nextState = exMem;
          ADDI: nextState = exI;
          LUI: begin
            nextState = luiWb;
            nextCtrl = '0;
            nextCtrl.regWrite = 1'b1;
            nextCtrl.regDst = dstRt;
            nextCtrl.memToReg = wbUpper;
          end
          BEQ, BNE: begin
            nextState = (instr.r.opcode == BEQ) ? exBeq : exBne;
            nextCtrl = aluWord(srcARs, srcBReg, aluSub);
            nextCtrl.pcWriteCond = 1'b1;
            nextCtrl.branchOnEqual = (instr.r.opcode == BEQ);
            nextCtrl.pcSource = pcFromAluOut;
          end
          J: begin
            nextState = exJ;
            nextCtrl = '0;
            nextCtrl.pcWrite = 1'b1;
            nextCtrl.pcSource = pcFromJump;
          end
          default: begin
            nextState = errorState;
            nextCtrl = '0;
          end
        endcase
      end
      exMem: begin
        nextCtrl.iOrD = 1'b1; // ALU fields kept so the address stays put
        if (instr.r.opcode == LW) begin
          nextState = memRd;
          nextCtrl.memRead = 1'b1;
        end else if (instr.r.opcode == SW) begin
          nextState = memWr;
          nextCtrl.memWrite = 1'b1;
        end else begin
          nextState = errorState;
          nextCtrl = '0;
        end
      end
      exR, exI: begin
        nextState = (state == exR) ? wbR : wbI;
        nextCtrl = '0;
        nextCtrl.regWrite = 1'b1;
        nextCtrl.regDst = (state == exR) ? dstRd : dstRt;
        nextCtrl.memToReg = wbAlu;
      end
      memRd: begin
        if (memReady) begin
          nextState = wbLw;
          nextCtrl = '0;
          nextCtrl.regWrite = 1'b1;
          nextCtrl.regDst = dstRt;
          nextCtrl.memToReg = wbMem;
        end
      end
      memWr: begin
        if (memReady) begin
          nextState = fetch;
          nextCtrl = fetchCtrl;
        end
      end
      wbR, wbI, wbLw, luiWb, exJ, exBeq, exBne: begin
        nextState = fetch;
        nextCtrl = fetchCtrl;
      end
      errorState: nextCtrl = '0; // Parked until reset
      default: begin
        nextState = errorState;
        nextCtrl = '0;
      end
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= fetch;
      ctrl <= fetchCtrl;
    end else begin
      state <= nextState;
      ctrl <= nextCtrl;
    end
  end

endmodule

`default_nettype wire

/* hw/mcCpu.sv */
`timescale 1ns/10ps
`default_nettype none

module mcCpu
  import isaPkg::*, ctrlPkg::*;
(
  input  wire logic clk,
  input  wire logic reset,
  input  word_t     memData,
  input  wire logic memReady,
  output memReq_t   memReq,
  output word_t     pc,
  output instr_t    instr,
  output cpuState_t state
);

  ctrlWord_t ctrl;

  ctrlFsm u_ctrlFsm (
    .clk(clk),
    .reset(reset),
    .instr(instr),
    .memReady(memReady),
    .ctrl(ctrl),
    .state(state)
  );

  dataPath u_dataPath (
    .clk(clk),
    .reset(reset),
    .ctrl(ctrl),
    .memData(memData),
    .memReady(memReady),
    .memReq(memReq),
    .instr(instr),
    .pc(pc)
  );

endmodule

`default_nettype wire

/* tests/memModel.sv */
`timescale 1ns/10ps
`default_nettype none

module memModel
  import isaPkg::*;
(
  input  wire logic    clk,
  input  wire logic    reset,
  input  memReq_t      memReq,
  input  word_t [31:0] image,
  output word_t        memData,
  output logic         memReady
);

  localparam int unsigned rngSeed = 51959;
  localparam int depth = 64;
  localparam int logDepth = 8;

  word_t mem [depth];
  word_t logAddr [logDepth];
  word_t logData [logDepth];
  int storeCount;
  int waitLeft;

  initial begin
    void'($urandom(rngSeed));
    memData = '0;
    memReady = 1'b0;
    storeCount = 0;
    waitLeft = 0;
    forever begin
      @(negedge clk);
      if (reset) begin
        for (int i = 0; i < 32; i++) begin
          mem[i] = image[i];
        end
        for (int i = 32; i < depth; i++) begin
          mem[i] = 32'hBAD0_0000 | (i << 2); // Fill tied to byte address
        end
        storeCount = 0;
        waitLeft = $urandom % 4;
        memReady <= 1'b0;
      end else begin
        if (memReady) begin
          waitLeft = $urandom % 4; // Last access closed on the rising edge
        end
        memReady <= 1'b0;
        if (memReq.read || memReq.write) begin
          if (waitLeft == 0) begin
            memReady <= 1'b1;
            if (memReq.write) begin
              mem[memReq.addr[7:2]] = memReq.wdata;
              if (storeCount < logDepth) begin
                logAddr[storeCount] = memReq.addr;
                logData[storeCount] = memReq.wdata;
              end
              storeCount++;
            end else begin
              memData <= mem[memReq.addr[7:2]];
            end
          end else begin
            waitLeft--;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* tests/tbMcCpu.sv */
`timescale 1ns/10ps
`default_nettype none

module tbMcCpu
  import isaPkg::*, ctrlPkg::*;
();

  typedef enum logic [3:0] {
    opAdd, opSub, opAnd, opOr, opNor, opSlt,
    opAddi, opLui, opBeq, opBne, opJump, opZero
  } testKind_t;

  typedef struct packed {
    testKind_t kind;
    word_t a;
    word_t b;
    logic [15:0] imm;
    word_t expected;
  } testEntry_t;

  typedef word_t [31:0] image_t;

  localparam int numTests = 17;
  localparam int cycleLimit = numTests * 12 * 17; // 5 states plus 3 waits on 4 accesses
  localparam logic [15:0] storeAddr = 16'h0080;
  localparam word_t illegalWord = 32'hFC00_0000;

  localparam testEntry_t tests [numTests] = '{
    '{opAdd,  32'h7FFF_FFFF, 32'h0000_0001, 16'h0000, 32'h8000_0000},
    '{opAdd,  32'hFFFF_FFFF, 32'h0000_0002, 16'h0000, 32'h0000_0001},
    '{opSub,  32'h0000_0005, 32'h0000_0007, 16'h0000, 32'hFFFF_FFFE},
    '{opAnd,  32'hF0F0_1234, 32'h0FF0_FF00, 16'h0000, 32'h00F0_1200},
    '{opOr,   32'hF0F0_1234, 32'h0FF0_FF00, 16'h0000, 32'hFFF0_FF34},
    '{opNor,  32'h0000_FF00, 32'h00FF_0000, 16'h0000, 32'hFF00_00FF},
    '{opSlt,  32'hFFFF_FFF0, 32'h0000_0003, 16'h0000, 32'h0000_0001},
    '{opSlt,  32'h0000_0003, 32'hFFFF_FFF0, 16'h0000, 32'h0000_0000},
    '{opAddi, 32'h0000_0064, 32'h0000_0000, 16'hFFFF, 32'h0000_0063},
    '{opAddi, 32'h0000_0064, 32'h0000_0000, 16'h0010, 32'h0000_0074},
    '{opLui,  32'h0000_0000, 32'h0000_0000, 16'hBEEF, 32'hBEEF_0000},
    '{opBeq,  32'h0000_0009, 32'h0000_0009, 16'h0000, 32'h0000_0001},
    '{opBeq,  32'h0000_0009, 32'h0000_0008, 16'h0000, 32'h0000_0002},
    '{opBne,  32'h0000_0009, 32'h0000_0008, 16'h0000, 32'h0000_0001},
    '{opBne,  32'h0000_0009, 32'h0000_0009, 16'h0000, 32'h0000_0002},
    '{opJump, 32'h0000_0000, 32'h0000_0000, 16'h0000, 32'h0000_0001},
    '{opZero, 32'h0000_0005, 32'h0000_0006, 16'h0000, 32'h0000_0000}
  };

  logic clk = 1'b0;
  logic reset;
  image_t image;
  memReq_t memReq;
  word_t memData;
  logic memReady;
  word_t pc;
  instr_t instr;
  cpuState_t state;
  int cycles = 0;
  int passCount;
  int failCount;

  mcCpu u_mcCpu (
    .clk(clk),
    .reset(reset),
    .memData(memData),
    .memReady(memReady),
    .memReq(memReq),
    .pc(pc),
    .instr(instr),
    .state(state)
  );

  memModel u_memModel (
    .clk(clk),
    .reset(reset),
    .memReq(memReq),
    .image(image),
    .memData(memData),
    .memReady(memReady)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("Timeout, the CPU did not park within %0d cycles", cycleLimit);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic word_t rTypeWord(input funct_t f, input regAddr_t rs,
                                      input regAddr_t rt, input regAddr_t rd);
    rType_t w;
    w.opcode = RTYPE;
    w.rs = rs;
    w.rt = rt;
    w.rd = rd;
    w.shamt = 5'd0;
    w.funct = f;
    return w;
  endfunction

  function automatic word_t immWord(input opcode_t op, input regAddr_t rs,
                                    input regAddr_t rt, input logic [15:0] imm);
    iType_t w;
    w.opcode = op;
    w.rs = rs;
    w.rt = rt;
    w.imm = imm;
    return w;
  endfunction

  function automatic word_t jumpWord(input logic [25:0] target);
    jType_t w;
    w.opcode = J;
    w.target = target; // Word address
    return w;
  endfunction

  function automatic funct_t functFor(input testKind_t kind);
    case (kind)
      opSub:   return SUB;
      opAnd:   return AND;
      opOr:    return OR;
      opNor:   return NOR;
      opSlt:   return SLT;
      default: return ADD;
    endcase
  endfunction

  // Word slot of the final store, the parking word follows it
  function automatic int storeSlot(input testKind_t kind);
    case (kind)
      opBeq, opBne, opJump: return 6;
      default:              return 3;
    endcase
  endfunction

  // Operands at 0x40 and 0x44, result stored to 0x80
  function automatic image_t buildImage(input testEntry_t t);
    image_t prog;
    int storeAt;
    prog = '0;
    storeAt = storeSlot(t.kind);
    prog[16] = t.a;
    prog[17] = t.b;
    prog[0] = immWord(LW, 5'd0, 5'd1, 16'h0040);
    prog[1] = immWord(LW, 5'd0, 5'd2, 16'h0044);
    case (t.kind)
      opAddi: prog[2] = immWord(ADDI, 5'd1, 5'd3, t.imm);
      opLui:  prog[2] = immWord(LUI, 5'd0, 5'd3, t.imm);
      opZero: prog[2] = rTypeWord(ADD, 5'd1, 5'd2, 5'd0);
      opBeq, opBne: begin
        prog[2] = immWord((t.kind == opBeq) ? BEQ : BNE, 5'd1, 5'd2, 16'd2); // To word 5
        prog[3] = immWord(ADDI, 5'd0, 5'd3, 16'd2);
        prog[4] = jumpWord(26'd6);
        prog[5] = immWord(ADDI, 5'd0, 5'd3, 16'd1);
      end
      opJump: begin
        prog[2] = jumpWord(26'd5);
        prog[3] = immWord(ADDI, 5'd0, 5'd3, 16'd2);
        prog[4] = immWord(SW, 5'd0, 5'd3, storeAddr); // Must be skipped
        prog[5] = immWord(ADDI, 5'd0, 5'd3, 16'd1);
      end
      default: prog[2] = rTypeWord(functFor(t.kind), 5'd1, 5'd2, 5'd3);
    endcase
    prog[storeAt] = immWord(SW, 5'd0, (t.kind == opZero) ? 5'd0 : 5'd3, storeAddr);
    prog[storeAt + 1] = illegalWord;
    return prog;
  endfunction

  task automatic runTest(input int idx);
    testEntry_t t;
    testKind_t kind;
    string name;
    logic ok;
    word_t parkPc;
    t = tests[idx];
    kind = t.kind;
    name = $sformatf("%s#%0d", kind.name(), idx);
    ok = 1'b1;
    @(negedge clk);
    reset <= 1'b1;
    image <= buildImage(t);
    repeat (2) @(negedge clk);
    reset <= 1'b0;
    while (state != errorState) begin
      @(negedge clk);
    end
    repeat (8) @(negedge clk); // Watch for stray writes while parked
    assert (state == errorState) else begin
      $display("%s: CPU left the error state without a reset", name);
      ok = 1'b0;
    end
    parkPc = (storeSlot(kind) + 2) * 4; // PC already past the parking word
    assert (pc == parkPc) else begin
      $display("MISMATCH %s pc expected %h actual %h", name, parkPc, pc);
      ok = 1'b0;
    end
    assert (instr == illegalWord) else begin
      $display("MISMATCH %s instr expected %h actual %h", name, illegalWord, instr);
      ok = 1'b0;
    end
    assert (u_memModel.storeCount != 0) else begin
      $display("%s: no store reached memory before the CPU parked", name);
      ok = 1'b0;
    end
    assert (u_memModel.storeCount <= 1) else begin
      $display("%s: expected one memory write but saw %0d", name, u_memModel.storeCount);
      ok = 1'b0;
    end
    if (u_memModel.storeCount != 0) begin
      assert (u_memModel.logAddr[0] == {16'h0000, storeAddr}) else begin
        $display("MISMATCH %s address expected %h actual %h", name,
                 {16'h0000, storeAddr}, u_memModel.logAddr[0]);
        ok = 1'b0;
      end
      assert (u_memModel.logData[0] == t.expected) else begin
        $display("MISMATCH %s expected %h actual %h", name, t.expected,
                 u_memModel.logData[0]);
        ok = 1'b0;
      end
    end
    $display("%s %s", name, ok ? "passed" : "failed");
    if (ok) passCount++;
    else failCount++;
  endtask

  initial begin
    reset = 1'b1;
    image = '0;
    passCount = 0;
    failCount = 0;
    for (int i = 0; i < numTests; i++) begin
      runTest(i);
    end
    $display("%0d passed, %0d failed", passCount, failCount);
    if (failCount == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* mcCpu.f */
common/isaPkg.sv
common/ctrlPkg.sv
datapath/alu.sv
datapath/regFile.sv
datapath/dataPath.sv
control/ctrlFsm.sv
hw/mcCpu.sv
tests/memModel.sv
tests/tbMcCpu.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tbMcCpu
FILELIST   := mcCpu.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0
OBJDIR     := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
